//--- common/flash_rd_if.sv
`timescale 1ns/1ps

interface flash_rd_if;
  import ipod_pkg::*;

  // Request side
  logic              read;
  logic [ADDR_W-1:0] address;

  // Response side
  logic              waitrequest;
  flash_word_u       readdata;
  logic              readdatavalid;

  modport master (
    output read,
    output address,
    input  waitrequest,
    input  readdata,
    input  readdatavalid
  );

  modport memory (
    input  read,
    input  address,
    output waitrequest,
    output readdata,
    output readdatavalid
  );

endinterface

//--- common/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Playback speed
  // ==================================================

  localparam int DIV_W = 24;

  // About 44 kHz from the 50 MHz clock
  localparam logic [DIV_W-1:0] DEFAULT_DIVISOR = 24'd1136;
  localparam logic [DIV_W-1:0] DIVISOR_STEP    = 24'd16;
  localparam logic [DIV_W-1:0] MIN_DIVISOR     = 24'd256;
  localparam logic [DIV_W-1:0] MAX_DIVISOR     = 24'd65520;

  // ==================================================
  // Flash words and samples
  // ==================================================

  localparam int ADDR_W = 23;

  // Last word of the sound clip
  localparam logic [ADDR_W-1:0] LAST_WORD = 23'h7FFFF;

  typedef logic [15:0] sample_t;

  // One flash word, either raw or as two samples
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      sample_t hi;
      sample_t lo;
    } half;
  } flash_word_u;

  // Read master states
  localparam logic [1:0] RD_IDLE = 2'd0;
  localparam logic [1:0] RD_REQ  = 2'd1;
  localparam logic [1:0] RD_WAIT = 2'd2;

  // ==================================================
  // ASCII commands
  // ==================================================

  localparam logic [7:0] CMD_PLAY     = 8'h45;  // 'E'
  localparam logic [7:0] CMD_PAUSE    = 8'h44;  // 'D'
  localparam logic [7:0] CMD_FORWARD  = 8'h46;  // 'F'
  localparam logic [7:0] CMD_BACKWARD = 8'h42;  // 'B'
  localparam logic [7:0] CMD_RESTART  = 8'h52;  // 'R'

endpackage

//--- files.f
common/ipod_pkg.sv
common/flash_rd_if.sv
hw/speed_control.sv
hw/seg7_display.sv
playback/playback_ctrl.sv
playback/flash_reader.sv
hw/simple_ipod_top.sv
tests/flash_model.sv
tests/ipod_properties.sv
tests/tb_simple_ipod.sv

//--- hw/seg7_display.sv
`timescale 1ns/1ps

module seg7_display (
  input  logic [ipod_pkg::DIV_W-1:0] divisor,
  output logic [6:0]                 hex0,
  output logic [6:0]                 hex1,
  output logic [6:0]                 hex2,
  output logic [6:0]                 hex3,
  output logic [6:0]                 hex4,
  output logic [6:0]                 hex5
);

  // Active-low segments, bit order gfedcba
  function automatic logic [6:0] seg_of(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // hex0 shows the lowest nibble
  assign hex0 = seg_of(divisor[3:0]);
  assign hex1 = seg_of(divisor[7:4]);
  assign hex2 = seg_of(divisor[11:8]);
  assign hex3 = seg_of(divisor[15:12]);
  assign hex4 = seg_of(divisor[19:16]);
  assign hex5 = seg_of(divisor[23:20]);

endmodule

//--- hw/simple_ipod_top.sv
`timescale 1ns/1ps

module simple_ipod_top (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic [2:0]                  key,
  input  logic [7:0]                  cmd_code,
  input  logic                        cmd_valid,
  output logic                        flash_read,
  output logic [ipod_pkg::ADDR_W-1:0] flash_address,
  input  logic                        flash_waitrequest,
  input  logic [31:0]                 flash_readdata,
  input  logic                        flash_readdatavalid,
  output ipod_pkg::sample_t           sample,
  output logic                        sample_valid,
  output logic [6:0]                  hex0,
  output logic [6:0]                  hex1,
  output logic [6:0]                  hex2,
  output logic [6:0]                  hex3,
  output logic [6:0]                  hex4,
  output logic [6:0]                  hex5
);
  import ipod_pkg::*;

  logic [DIV_W-1:0]  divisor;
  logic              fetch_req;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_done;
  flash_word_u       fetch_word;

  flash_rd_if flash_bus ();

  // Flash bus out to the pins
  assign flash_read                = flash_bus.read;
  assign flash_address             = flash_bus.address;
  assign flash_bus.waitrequest     = flash_waitrequest;
  assign flash_bus.readdata.raw    = flash_readdata;
  assign flash_bus.readdatavalid   = flash_readdatavalid;

  speed_control u_speed_control (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .key     (key),
    .divisor (divisor)
  );

  playback_ctrl u_playback_ctrl (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .cmd_code     (cmd_code),
    .cmd_valid    (cmd_valid),
    .divisor      (divisor),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_done   (fetch_done),
    .fetch_word   (fetch_word),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  flash_reader u_flash_reader (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_word (fetch_word),
    .flash      (flash_bus.master)
  );

  seg7_display u_seg7_display (
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

//--- hw/speed_control.sv
`timescale 1ns/1ps

module speed_control (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic [2:0]                 key,
  output logic [ipod_pkg::DIV_W-1:0] divisor
);
  import ipod_pkg::*;

  // Keys are active low, so everything idles at 1
  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_prev;
  logic [2:0] press;

  logic [DIV_W-1:0] div_faster;
  logic [DIV_W-1:0] div_slower;

  // Two-flop synchronizer plus previous value for edge detection
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
      key_prev <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  // One pulse on the first synchronized low sample
  assign press = key_prev & ~key_sync;

  // Clamped next values
  assign div_faster = (divisor >= MIN_DIVISOR + DIVISOR_STEP) ?
                      divisor - DIVISOR_STEP : MIN_DIVISOR;
  assign div_slower = (divisor <= MAX_DIVISOR - DIVISOR_STEP) ?
                      divisor + DIVISOR_STEP : MAX_DIVISOR;

  // Reset key wins over the other two
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      divisor <= DEFAULT_DIVISOR;
    end
    else if (press[2])
    begin
      divisor <= DEFAULT_DIVISOR;
    end
    else if (press[0])
    begin
      divisor <= div_faster;
    end
    else if (press[1])
    begin
      divisor <= div_slower;
    end
  end

endmodule

//--- playback/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic                        fetch_req,
  input  logic [ipod_pkg::ADDR_W-1:0] fetch_addr,
  output logic                        fetch_done,
  output ipod_pkg::flash_word_u       fetch_word,
  flash_rd_if.master                  flash
);
  import ipod_pkg::*;

  logic [1:0]        state;
  logic [ADDR_W-1:0] addr_q;
  logic              accept;
  logic              capture;

  // Request taken when wait-request is low
  assign accept  = (state == RD_REQ) && !flash.waitrequest;
  assign capture = (state == RD_WAIT) && flash.readdatavalid;

  // Read is high only in the request state, so it holds through wait-request
  assign flash.read    = (state == RD_REQ);
  assign flash.address = addr_q;

  // ==================================================
  // Read FSM
  // ==================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= RD_IDLE;
      fetch_done <= 1'b0;
    end
    else
    begin
      fetch_done <= 1'b0;
      case (state)
        RD_IDLE:
        begin
          if (fetch_req)
            state <= RD_REQ;
        end
        RD_REQ:
        begin
          if (accept)
            state <= RD_WAIT;
        end
        RD_WAIT:
        begin
          if (capture)
          begin
            fetch_done <= 1'b1;
            state      <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // Address latched with the request, word latched on valid
  always_ff @(posedge CLK_50M)
  begin
    if (state == RD_IDLE && fetch_req)
    begin
      addr_q <= fetch_addr;
    end
    if (capture)
    begin
      fetch_word.raw <= flash.readdata.raw;
    end
  end

endmodule

//--- playback/playback_ctrl.sv
`timescale 1ns/1ps

module playback_ctrl (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic [7:0]                  cmd_code,
  input  logic                        cmd_valid,
  input  logic [ipod_pkg::DIV_W-1:0]  divisor,
  output logic                        fetch_req,
  output logic [ipod_pkg::ADDR_W-1:0] fetch_addr,
  input  logic                        fetch_done,
  input  ipod_pkg::flash_word_u       fetch_word,
  output ipod_pkg::sample_t           sample,
  output logic                        sample_valid
);
  import ipod_pkg::*;

  logic              playing;
  logic              backward;
  logic              next_high;   // Half of the held word to play next
  logic              need_load;   // Held word does not belong to addr
  logic              fetch_busy;
  logic              stale;       // Outstanding word was overtaken by a restart
  logic [ADDR_W-1:0] addr;
  logic [DIV_W-1:0]  tick_cnt;
  flash_word_u       held_word;
  flash_word_u       src_word;

  logic tick;
  logic start_fetch;
  logic refill;
  logic emit;

  // ==================================================
  // Sample tick and emit decisions
  // ==================================================

  assign tick        = playing && (tick_cnt >= divisor - 1'b1);
  assign start_fetch = tick && !fetch_busy && need_load;
  assign refill      = fetch_done && !stale && playing;
  assign emit        = (tick && !fetch_busy && !need_load) || refill;
  assign src_word    = fetch_done ? fetch_word : held_word;

  always_ff @(posedge CLK_50M)
  begin
    if (start_fetch)
    begin
      fetch_addr <= addr;
    end
    if (fetch_done)
    begin
      held_word <= fetch_word;
    end
    if (emit)
    begin
      sample <= next_high ? src_word.half.hi : src_word.half.lo;
    end
  end

  // ==================================================
  // Control state
  // ==================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      playing      <= 1'b0;
      backward     <= 1'b0;
      next_high    <= 1'b0;
      need_load    <= 1'b1;
      fetch_busy   <= 1'b0;
      stale        <= 1'b0;
      addr         <= '0;
      tick_cnt     <= '0;
      fetch_req    <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      fetch_req    <= start_fetch;
      sample_valid <= emit;

      // Restart the period after a refill so samples keep their spacing
      if (!playing || tick || refill)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;

      if (start_fetch)
        fetch_busy <= 1'b1;

      if (fetch_done)
      begin
        fetch_busy <= 1'b0;
        stale      <= 1'b0;
        if (!stale)
          need_load <= 1'b0;
      end

      // Advance once the last half in the current order is used
      if (emit)
      begin
        if (!backward && next_high)
        begin
          addr      <= (addr == LAST_WORD) ? '0 : addr + 1'b1;
          need_load <= 1'b1;
          next_high <= 1'b0;
        end
        else if (backward && !next_high)
        begin
          addr      <= (addr == '0) ? LAST_WORD : addr - 1'b1;
          need_load <= 1'b1;
          next_high <= 1'b1;
        end
        else
        begin
          next_high <= ~next_high;
        end
      end

      // Commands come last and override the above
      if (cmd_valid)
      begin
        case (cmd_code)
          CMD_PLAY:
          begin
            if (!playing)
            begin
              playing   <= 1'b1;
              need_load <= 1'b1;
            end
          end
          CMD_PAUSE:    playing  <= 1'b0;
          CMD_FORWARD:  backward <= 1'b0;
          CMD_BACKWARD: backward <= 1'b1;
          CMD_RESTART:
          begin
            addr      <= backward ? LAST_WORD : '0;
            next_high <= backward;
            need_load <= 1'b1;
            if ((fetch_busy && !fetch_done) || start_fetch)
              stale <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status reflects pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_simple_ipod \
  -f files.f \
  -o Vtb_simple_ipod

./obj_dir/Vtb_simple_ipod

//--- tests/flash_model.sv
`timescale 1ns/1ps

module flash_model (
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic                        read,
  input  logic [ipod_pkg::ADDR_W-1:0] address,
  output logic                        waitrequest,
  output logic [31:0]                 readdata,
  output logic                        readdatavalid
);
  import ipod_pkg::*;

  integer            seed = 32'h87dd8de5;
  logic [3:0]        wait_cnt;
  logic [3:0]        valid_cnt;
  logic              busy;
  logic [ADDR_W-1:0] addr_q;

  // Stalls any request until the wait count runs out
  assign waitrequest = (wait_cnt != 4'd0);

  always @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_cnt      <= 4'($random(seed));
      valid_cnt     <= 4'd0;
      busy          <= 1'b0;
      addr_q        <= '0;
      readdata      <= 32'h0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (busy)
      begin
        if (valid_cnt == 4'd0)
        begin
          // High half is address plus 0x4000, low half is the address
          readdata      <= {addr_q[15:0] + 16'h4000, addr_q[15:0]};
          readdatavalid <= 1'b1;
          busy          <= 1'b0;
        end
        else
          valid_cnt <= valid_cnt - 4'd1;
      end
      else if (read)
      begin
        if (wait_cnt == 4'd0)
        begin
          addr_q    <= address;
          busy      <= 1'b1;
          valid_cnt <= 4'($random(seed));
          wait_cnt  <= 4'($random(seed));
        end
        else
          wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

endmodule

//--- tests/ipod_properties.sv
`timescale 1ns/1ps

module ipod_properties (
  input logic                        CLK_50M,
  input logic                        rst_n,
  input logic                        read,
  input logic [ipod_pkg::ADDR_W-1:0] address,
  input logic                        waitrequest,
  input logic                        readdatavalid,
  input logic                        fetch_done
);

  // Set from acceptance until the word comes back
  logic outstanding;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 1'b0;
    else if (read && !waitrequest)
      outstanding <= 1'b1;
    else if (readdatavalid)
      outstanding <= 1'b0;
  end

  // Request held steady through wait-request
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (read && waitrequest) |=> (read && $stable(address)))
    else $error("flash read or address changed while waitrequest was high");

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    outstanding |-> !read)
    else $error("flash read raised while a read was still outstanding");

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    fetch_done |=> !fetch_done)
    else $error("fetch_done lasted longer than one cycle");

endmodule

bind flash_reader ipod_properties u_ipod_properties (
  .CLK_50M       (CLK_50M),
  .rst_n         (rst_n),
  .read          (flash.read),
  .address       (flash.address),
  .waitrequest   (flash.waitrequest),
  .readdatavalid (flash.readdatavalid),
  .fetch_done    (fetch_done)
);

//--- tests/tb_simple_ipod.sv
`timescale 1ns/1ps

module tb_simple_ipod;
  import ipod_pkg::*;

  localparam int ACT_IDLE   = 0;
  localparam int ACT_KEY    = 1;
  localparam int ACT_CMD    = 2;
  localparam int PRESS_HALF = 4;

  // Count is divisor periods for idle rows, presses for key rows, samples for commands
  typedef struct {
    int               kind;
    logic [7:0]       code;
    int               count;
    logic [DIV_W-1:0] exp_div;
  } row_t;

  logic              CLK_50M;
  logic              rst_n;
  logic [2:0]        key;
  logic [7:0]        cmd_code;
  logic              cmd_valid;
  logic              flash_read;
  logic [ADDR_W-1:0] flash_address;
  logic              flash_waitrequest;
  logic [31:0]       flash_readdata;
  logic              flash_readdatavalid;
  sample_t           sample;
  logic              sample_valid;
  logic [6:0]        hex0;
  logic [6:0]        hex1;
  logic [6:0]        hex2;
  logic [6:0]        hex3;
  logic [6:0]        hex4;
  logic [6:0]        hex5;

  row_t              rows[$];
  int                cycle_cnt;
  int                cycle_limit;
  logic [ADDR_W-1:0] exp_addr;
  logic              exp_high;
  logic              exp_back;

  simple_ipod_top UUT (.*);

  flash_model u_flash_model (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Failure reporting and checks
  // ==================================================

  task automatic abort_run;
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  always @(posedge CLK_50M)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic check_divisor(input logic [DIV_W-1:0] got, input logic [DIV_W-1:0] exp);
    if (got !== exp)
    begin
      $display("** Error: divisor = 0x%06h, expected 0x%06h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp);
    if (got !== exp)
    begin
      $display("** Error: sample = 0x%04h, expected 0x%04h", got, exp);
      abort_run();
    end
  endtask

  // Inverse of the active-low gfedcba patterns
  // Bit 4 set marks a valid digit
  function automatic logic [4:0] nibble_of_seg(input logic [6:0] seg);
    case (seg)
      7'b1000000: return 5'h10;
      7'b1111001: return 5'h11;
      7'b0100100: return 5'h12;
      7'b0110000: return 5'h13;
      7'b0011001: return 5'h14;
      7'b0010010: return 5'h15;
      7'b0000010: return 5'h16;
      7'b1111000: return 5'h17;
      7'b0000000: return 5'h18;
      7'b0010000: return 5'h19;
      7'b0001000: return 5'h1A;
      7'b0000011: return 5'h1B;
      7'b1000110: return 5'h1C;
      7'b0100001: return 5'h1D;
      7'b0000110: return 5'h1E;
      7'b0001110: return 5'h1F;
      default:    return 5'h00;
    endcase
  endfunction

  task automatic read_display(output logic [DIV_W-1:0] value);
    logic [6:0] digits [6];
    logic [4:0] dec;
    digits = '{hex0, hex1, hex2, hex3, hex4, hex5};
    value = '0;
    for (int i = 0; i < 6; i++)
    begin
      dec = nibble_of_seg(digits[i]);
      if (!dec[4])
      begin
        $display("Digit hex%0d shows pattern 0x%02h, which is no hex character", i, digits[i]);
        abort_run();
      end
      value[4*i +: 4] = dec[3:0];
    end
  endtask

  // ==================================================
  // Expected samples
  // ==================================================

  function automatic sample_t expected_sample(input logic [ADDR_W-1:0] addr, input logic high);
    return high ? addr[15:0] + 16'h4000 : addr[15:0];
  endfunction

  // Forward plays low then high, backward high then low
  task automatic advance_model;
    if (!exp_back && exp_high)
    begin
      exp_addr = (exp_addr == LAST_WORD) ? '0 : exp_addr + ADDR_W'(1);
      exp_high = 1'b0;
    end
    else if (exp_back && !exp_high)
    begin
      exp_addr = (exp_addr == '0) ? LAST_WORD : exp_addr - ADDR_W'(1);
      exp_high = 1'b1;
    end
    else
      exp_high = !exp_high;
  endtask

  task automatic model_command(input logic [7:0] code);
    case (code)
      CMD_FORWARD:  exp_back = 1'b0;
      CMD_BACKWARD: exp_back = 1'b1;
      CMD_RESTART:
      begin
        exp_addr = exp_back ? LAST_WORD : '0;
        exp_high = exp_back;
      end
      default: ;
    endcase
  endtask

  // ==================================================
  // Stimulus
  // ==================================================

  task automatic press_key(input int idx);
    @(posedge CLK_50M);
    key[idx] <= 1'b0;
    repeat (PRESS_HALF) @(posedge CLK_50M);
    key[idx] <= 1'b1;
    repeat (PRESS_HALF - 1) @(posedge CLK_50M);
  endtask

  task automatic send_command(input logic [7:0] code);
    @(posedge CLK_50M);
    cmd_code  <= code;
    cmd_valid <= 1'b1;
    @(posedge CLK_50M);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_for_sample(output int gap);
    gap = 0;
    do
    begin
      @(negedge CLK_50M);
      gap++;
    end
    while (!sample_valid);
  endtask

  task automatic observe_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge CLK_50M);
      if (sample_valid)
      begin
        $display("sample_valid went high while playback should be silent");
        abort_run();
      end
    end
  endtask

  task automatic run_row(input row_t r);
    int               gap;
    logic [DIV_W-1:0] shown;
    case (r.kind)
      ACT_IDLE: observe_quiet(r.count * int'(r.exp_div));
      ACT_KEY:  repeat (r.count) press_key(int'(r.code));
      default:
      begin
        send_command(r.code);
        model_command(r.code);
        for (int i = 0; i < r.count; i++)
        begin
          wait_for_sample(gap);
          if (i > 0 && gap < int'(r.exp_div))
          begin
            $display("Samples came %0d cycles apart, less than the divisor %0d",
                     gap, r.exp_div);
            abort_run();
          end
          check_sample(sample, expected_sample(exp_addr, exp_high));
          advance_model();
        end
      end
    endcase
    @(negedge CLK_50M);
    read_display(shown);
    check_divisor(shown, r.exp_div);
  endtask

  initial
  begin
    rst_n     = 1'b0;
    key       = 3'b111;
    cmd_code  = 8'h00;
    cmd_valid = 1'b0;
    exp_addr  = '0;
    exp_high  = 1'b0;
    exp_back  = 1'b0;

    // Keys 0 up, 1 down, 2 reset
    rows.push_back('{ACT_IDLE, 8'd0, 2, DEFAULT_DIVISOR});
    rows.push_back('{ACT_KEY, 8'd0, 3, 24'd1088});
    rows.push_back('{ACT_KEY, 8'd1, 2, 24'd1120});
    rows.push_back('{ACT_KEY, 8'd2, 1, DEFAULT_DIVISOR});
    rows.push_back('{ACT_KEY, 8'd1, 4030, MAX_DIVISOR});
    rows.push_back('{ACT_KEY, 8'd2, 1, DEFAULT_DIVISOR});
    rows.push_back('{ACT_KEY, 8'd0, 60, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_PLAY, 12, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_PAUSE, 0, MIN_DIVISOR});
    rows.push_back('{ACT_IDLE, 8'd0, 5, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_PLAY, 6, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_BACKWARD, 24, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_RESTART, 4, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_FORWARD, 0, MIN_DIVISOR});
    rows.push_back('{ACT_CMD, CMD_RESTART, 4, MIN_DIVISOR});

    // Worst case every observed period runs at the slowest divisor
    cycle_limit = 10000;
    foreach (rows[i])
    begin
      if (rows[i].kind == ACT_KEY)
        cycle_limit += rows[i].count * 2 * PRESS_HALF;
      else
        cycle_limit += rows[i].count * int'(MAX_DIVISOR);
    end

    repeat (10) @(posedge CLK_50M);
    rst_n <= 1'b1;

    foreach (rows[i])
      run_row(rows[i]);

    $display("=== PASS ===");
    $finish;
  end

endmodule
